// File: hw/exec_pkg.sv
package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN      = 64;
    localparam int ROBID_W   = 6;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      t_xdata;
    typedef logic [ROBID_W-1:0]   t_robid;
    typedef logic [REG_IDX_W-1:0] t_reg_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Micro-op kinds produced by the decoder
    typedef enum logic [4:0] {
        U_INV,
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_LUI,
        U_BR,
        U_JAL,
        U_JALR
    } t_uop;

    // Branch funct3 values as in the RISC-V base ISA
    typedef enum logic [2:0] {
        RV_BR_BEQ  = 3'b000,
        RV_BR_BNE  = 3'b001,
        RV_BR_BLT  = 3'b100,
        RV_BR_BGE  = 3'b101,
        RV_BR_BLTU = 3'b110,
        RV_BR_BGEU = 3'b111
    } t_br_cond;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        t_uop     uop;
        t_br_cond funct3;
        logic     use_imm;    // Second ALU operand comes from imm64
        t_reg_idx rd;
        t_reg_idx rs1;
        t_reg_idx rs2;
        t_xdata   imm64;      // Already sign extended by decode
        t_xdata   pc;
    } t_uinstr;

    typedef struct packed {
        t_uinstr uinstr;
        t_robid  robid;
    } t_iss_pkt;

    // Issue packet with both operands resolved
    typedef struct packed {
        t_iss_pkt iss_pkt;
        t_xdata   src1val;
        t_xdata   src2val;
    } t_ex_pkt;

    typedef struct packed {
        t_robid   robid;
        t_reg_idx rd;
        logic     wr_en;
        t_xdata   data;
    } t_wb_pkt;

    typedef struct packed {
        logic   valid;
        t_xdata target_addr;
        t_robid robid;
    } t_br_mispred_pkt;

endpackage

// File: hw/exec_operand_read.sv
`timescale 1ns/1ps

module exec_operand_read (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              iss,
    input  exec_pkg::t_iss_pkt iss_pkt,

    input  logic              wb_vld,
    input  exec_pkg::t_wb_pkt  wb_pkt,

    input  exec_pkg::t_xdata   ex_result,
    input  logic              ex_wr,

    output logic              ex_vld,
    output exec_pkg::t_ex_pkt  ex_pkt
);

    import exec_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Architectural register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    t_xdata   rf [1:31];     // x0 has no storage
    logic     rf_we;

    t_reg_idx src_idx [2];
    t_xdata   src_val [2];
    logic     ex_fwd;
    logic     wb_fwd;
    t_reg_idx ex_rd;
    t_ex_pkt  ex_pkt_d;

    assign rf_we = wb_vld && wb_pkt.wr_en && (wb_pkt.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[wb_pkt.rd] <= wb_pkt.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign src_idx[0] = iss_pkt.uinstr.rs1;
    assign src_idx[1] = iss_pkt.uinstr.rs2;

    assign ex_rd  = ex_pkt.iss_pkt.uinstr.rd;
    assign ex_fwd = ex_vld && ex_wr;              // Op in ex0 is about to write
    assign wb_fwd = wb_vld && wb_pkt.wr_en;       // Op in writeback not yet in the file

    // The youngest producer wins
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (src_idx[i] == '0) begin
                src_val[i] = '0;
            end else if (ex_fwd && (ex_rd == src_idx[i])) begin
                src_val[i] = ex_result;
            end else if (wb_fwd && (wb_pkt.rd == src_idx[i])) begin
                src_val[i] = wb_pkt.data;
            end else begin
                src_val[i] = rf[src_idx[i]];
            end
        end
    end

    always_comb begin
        ex_pkt_d.iss_pkt = iss_pkt;
        ex_pkt_d.src1val = src_val[0];
        ex_pkt_d.src2val = src_val[1];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue to ex0 register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_vld <= 1'b0;
        end else begin
            ex_vld <= iss;
        end
    end

    always_ff @(posedge clk) begin
        if (iss) begin
            ex_pkt <= ex_pkt_d;
        end
    end

endmodule

// File: hw/ibr.sv
`timescale 1ns/1ps

module ibr (
    input  logic                     ex_vld,
    input  exec_pkg::t_ex_pkt         ex_pkt,

    output logic                     resvld,
    output exec_pkg::t_xdata          result,
    output exec_pkg::t_br_mispred_pkt br_mispred_ex0
);

    import exec_pkg::*;

    t_uinstr uinstr;
    t_xdata  src1;
    t_xdata  src2;
    t_xdata  pcnxt;          // Not-taken path and the link value
    t_xdata  jalr_sum;
    t_xdata  tkn_tgt;
    t_xdata  tru_tgt;
    logic    tkn;

    assign uinstr = ex_pkt.iss_pkt.uinstr;
    assign src1   = ex_pkt.src1val;
    assign src2   = ex_pkt.src2val;

    assign resvld = ex_vld && (uinstr.uop inside {U_BR, U_JAL, U_JALR});
    assign pcnxt  = uinstr.pc + XLEN'(4);
    assign result = pcnxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Direction and target
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign jalr_sum = src1 + uinstr.imm64;

    // JALR drops bit 0 of the sum
    assign tkn_tgt = (uinstr.uop == U_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                            : uinstr.pc + uinstr.imm64;

    always_comb begin
        tkn = 1'b0;
        case (uinstr.uop)
            U_BR: begin
                case (uinstr.funct3)
                    RV_BR_BEQ:  tkn = (src1 == src2);
                    RV_BR_BNE:  tkn = (src1 != src2);
                    RV_BR_BLT:  tkn = ($signed(src1) <  $signed(src2));
                    RV_BR_BGE:  tkn = ($signed(src1) >= $signed(src2));
                    RV_BR_BLTU: tkn = (src1 <  src2);
                    RV_BR_BGEU: tkn = (src1 >= src2);
                    default:    tkn = 1'b0;
                endcase
            end
            U_JAL, U_JALR: tkn = 1'b1;        // Jumps never fall through
            default:       tkn = 1'b0;
        endcase
    end

    assign tru_tgt = tkn ? tkn_tgt : pcnxt;

    // Static not-taken prediction means any redirect away from pc+4 is a miss
    assign br_mispred_ex0.valid       = resvld && (tru_tgt != pcnxt);
    assign br_mispred_ex0.target_addr = tru_tgt;
    assign br_mispred_ex0.robid       = ex_pkt.iss_pkt.robid;

endmodule

// File: hw/ialu.sv
`timescale 1ns/1ps

module ialu (
    input  logic             ex_vld,
    input  exec_pkg::t_ex_pkt ex_pkt,

    output logic             resvld,
    output exec_pkg::t_xdata  result
);

    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    t_uinstr            uinstr;
    t_xdata             op1;
    t_xdata             op2;
    logic [SHAMT_W-1:0] shamt;
    logic               own_uop;

    assign uinstr = ex_pkt.iss_pkt.uinstr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign op1   = ex_pkt.src1val;
    assign op2   = uinstr.use_imm ? uinstr.imm64 : ex_pkt.src2val;
    assign shamt = op2[SHAMT_W-1:0];      // Only the low bits count for shifts

    always_comb begin
        case (uinstr.uop)
            U_ADD, U_SUB, U_AND, U_OR, U_XOR,
            U_SLL, U_SRL, U_SRA,
            U_SLT, U_SLTU, U_LUI: own_uop = 1'b1;
            default:              own_uop = 1'b0;
        endcase
    end

    assign resvld = ex_vld && own_uop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (uinstr.uop)
            U_ADD:  result = op1 + op2;
            U_SUB:  result = op1 - op2;
            U_AND:  result = op1 & op2;
            U_OR:   result = op1 | op2;
            U_XOR:  result = op1 ^ op2;
            U_SLL:  result = op1 << shamt;
            U_SRL:  result = op1 >> shamt;
            // Arithmetic shift fills with the sign bit
            U_SRA:  result = t_xdata'($signed(op1) >>> shamt);
            U_SLT:  result = XLEN'($signed(op1) < $signed(op2));
            U_SLTU: result = XLEN'(op1 < op2);
            U_LUI:  result = uinstr.imm64;    // Decode already placed the upper bits
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/exec_writeback.sv
`timescale 1ns/1ps

module exec_writeback (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     ex_vld,
    input  exec_pkg::t_ex_pkt         ex_pkt,

    input  logic                     alu_resvld,
    input  exec_pkg::t_xdata          alu_result,

    input  logic                     br_resvld,
    input  exec_pkg::t_xdata          br_result,
    input  exec_pkg::t_br_mispred_pkt br_mispred_ex0,

    output logic                     wb_vld,
    output exec_pkg::t_wb_pkt         wb_pkt,
    output exec_pkg::t_br_mispred_pkt br_mispred,

    output exec_pkg::t_xdata          ex_result,
    output logic                     ex_wr
);

    import exec_pkg::*;

    t_uinstr uinstr;
    logic    rd_nz;
    t_wb_pkt wb_pkt_d;
    logic    mispred_vld_q;
    t_xdata  mispred_tgt_q;
    t_robid  mispred_robid_q;

    assign uinstr = ex_pkt.iss_pkt.uinstr;
    assign rd_nz  = (uinstr.rd != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result select in ex0
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ex_result = alu_resvld ? alu_result :
                       br_resvld  ? br_result  : '0;

    // Conditional branches have no destination
    assign ex_wr = rd_nz && (alu_resvld || (br_resvld && (uinstr.uop != U_BR)));

    assign wb_pkt_d = '{robid: ex_pkt.iss_pkt.robid, rd: uinstr.rd,
                        wr_en: ex_wr, data: ex_result};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback stage registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_vld        <= 1'b0;
            mispred_vld_q <= 1'b0;
        end else begin
            wb_vld        <= ex_vld;     // Unclaimed ops still complete
            mispred_vld_q <= br_mispred_ex0.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_vld) begin
            wb_pkt <= wb_pkt_d;
        end
        if (br_mispred_ex0.valid) begin
            mispred_tgt_q   <= br_mispred_ex0.target_addr;
            mispred_robid_q <= br_mispred_ex0.robid;
        end
    end

    assign br_mispred = '{valid: mispred_vld_q, target_addr: mispred_tgt_q,
                          robid: mispred_robid_q};

endmodule

// File: hw/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     iss,
    input  exec_pkg::t_iss_pkt        iss_pkt,

    output logic                     wb_vld,
    output exec_pkg::t_wb_pkt         wb_pkt,
    output exec_pkg::t_br_mispred_pkt br_mispred
);

    import exec_pkg::*;

    // ex0 stage nets
    logic            ex_vld;
    t_ex_pkt         ex_pkt;
    logic            ex_wr;
    t_xdata          ex_result;

    // Unit results
    logic            alu_resvld;
    t_xdata          alu_result;
    logic            br_resvld;
    t_xdata          br_result;
    t_br_mispred_pkt br_mispred_ex0;

    exec_operand_read exec_operand_read_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss       (iss),
        .iss_pkt   (iss_pkt),
        .wb_vld    (wb_vld),
        .wb_pkt    (wb_pkt),
        .ex_result (ex_result),
        .ex_wr     (ex_wr),
        .ex_vld    (ex_vld),
        .ex_pkt    (ex_pkt)
    );

    ibr ibr_inst (
        .ex_vld         (ex_vld),
        .ex_pkt         (ex_pkt),
        .resvld         (br_resvld),
        .result         (br_result),
        .br_mispred_ex0 (br_mispred_ex0)
    );

    ialu ialu_inst (
        .ex_vld (ex_vld),
        .ex_pkt (ex_pkt),
        .resvld (alu_resvld),
        .result (alu_result)
    );

    exec_writeback exec_writeback_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_vld         (ex_vld),
        .ex_pkt         (ex_pkt),
        .alu_resvld     (alu_resvld),
        .alu_result     (alu_result),
        .br_resvld      (br_resvld),
        .br_result      (br_result),
        .br_mispred_ex0 (br_mispred_ex0),
        .wb_vld         (wb_vld),
        .wb_pkt         (wb_pkt),
        .br_mispred     (br_mispred),
        .ex_result      (ex_result),
        .ex_wr          (ex_wr)
    );

endmodule

// File: dv/exec_tb_table.svh
// Each row lists uop, funct3, use_imm, rd, rs1, rs2 and imm
// followed by the expected wr_en, data, mispredict and target
// Row n sits at pc 0x1000 + 4*n and carries robid n

task automatic load_table();
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register setup and ALU ops
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    add_row(U_ADD,  F3_NONE,    1,  1, 0, 0, 5,      1, 5,                      0, 0);
    add_row(U_ADD,  F3_NONE,    1,  2, 0, 0, -3,     1, -3,                     0, 0);
    add_row(U_ADD,  F3_NONE,    0,  3, 1, 2, 0,      1, 2,                      0, 0); // x1 comes from wb and x2 from ex0
    add_row(U_SUB,  F3_NONE,    0,  4, 3, 1, 0,      1, -3,                     0, 0);
    add_row(U_LUI,  F3_NONE,    1,  5, 0, 0, 64'h0000_0000_1234_5000,
            1, 64'h0000_0000_1234_5000, 0, 0);
    add_row(U_LUI,  F3_NONE,    1,  6, 0, 0, 64'hFFFF_FFFF_8000_0000,
            1, 64'hFFFF_FFFF_8000_0000, 0, 0);
    add_row(U_AND,  F3_NONE,    1,  7, 2, 0, 64'hF0, 1, 64'hF0,                 0, 0);
    add_row(U_OR,   F3_NONE,    0,  8, 5, 1, 0,      1, 64'h1234_5005,          0, 0);
    add_row(U_XOR,  F3_NONE,    1,  9, 2, 0, -1,     1, 2,                      0, 0);
    add_row(U_SLL,  F3_NONE,    1, 10, 1, 0, 4,      1, 64'h50,                 0, 0);
    add_row(U_SLL,  F3_NONE,    0, 11, 6, 1, 0,      1, 64'hFFFF_FFF0_0000_0000, 0, 0);
    add_row(U_SRL,  F3_NONE,    1, 12, 6, 0, 4,      1, 64'h0FFF_FFFF_F800_0000, 0, 0);
    add_row(U_SRA,  F3_NONE,    1, 13, 6, 0, 4,      1, 64'hFFFF_FFFF_F800_0000, 0, 0);
    add_row(U_SRA,  F3_NONE,    0, 14, 6, 2, 0,      1, -1,                     0, 0); // Shift of 61
    add_row(U_SLT,  F3_NONE,    0, 15, 2, 1, 0,      1, 1,                      0, 0);
    add_row(U_SLTU, F3_NONE,    0, 16, 2, 1, 0,      1, 0,                      0, 0);
    add_row(U_SLTU, F3_NONE,    1, 17, 1, 0, -1,     1, 1,                      0, 0);
    add_row(U_ADD,  F3_NONE,    1,  0, 1, 0, 7,      0, 0,                      0, 0); // Dropped
    add_row(U_ADD,  F3_NONE,    0, 18, 0, 1, 0,      1, 5,                      0, 0);
    add_row(U_ADD,  F3_NONE,    0, 19, 0, 18, 0,     1, 5,                      0, 0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Conditional branches with x1 = 5 and x2 = x4 = -3
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    add_row(U_BR,   RV_BR_BEQ,  0,  0, 2, 4, 64'h40, 0, 0,                      1, 64'h1090);
    add_row(U_BR,   RV_BR_BEQ,  0,  0, 1, 2, 64'h40, 0, 0,                      0, 0);
    add_row(U_BR,   RV_BR_BNE,  0,  0, 1, 2, -32,    0, 0,                      1, 64'h1038);
    add_row(U_BR,   RV_BR_BNE,  0,  0, 2, 4, 64'h10, 0, 0,                      0, 0);
    add_row(U_BR,   RV_BR_BLT,  0,  0, 2, 1, 8,      0, 0,                      1, 64'h1068);
    add_row(U_BR,   RV_BR_BLT,  0,  0, 1, 2, 8,      0, 0,                      0, 0);
    add_row(U_BR,   RV_BR_BGE,  0,  0, 1, 2, 64'h100, 0, 0,                     1, 64'h1168);
    add_row(U_BR,   RV_BR_BGE,  0,  0, 2, 1, 64'h100, 0, 0,                     0, 0);
    add_row(U_BR,   RV_BR_BLTU, 0,  0, 1, 2, 64'h20, 0, 0,                      1, 64'h1090);
    add_row(U_BR,   RV_BR_BLTU, 0,  0, 2, 1, 64'h20, 0, 0,                      0, 0);
    add_row(U_BR,   RV_BR_BGEU, 0,  0, 2, 1, -120,   0, 0,                      1, 64'h1000);
    add_row(U_BR,   RV_BR_BGEU, 0,  0, 1, 2, -120,   0, 0,                      0, 0);
    add_row(U_BR,   RV_BR_BEQ,  0,  9, 0, 0, 4,      0, 0,                      0, 0); // Lands on pc+4

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Jumps and late forwarding checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    add_row(U_JAL,  F3_NONE,    0, 21, 0, 0, 64'h100, 1, 64'h1088,              1, 64'h1184);
    add_row(U_JALR, F3_NONE,    0, 22, 21, 0, 64'h11, 1, 64'h108C,              1, 64'h1098);
    add_row(U_JAL,  F3_NONE,    0,  0, 0, 0, 4,      0, 0,                      0, 0);
    add_row(U_JALR, F3_NONE,    0, 23, 22, 0, 8,     1, 64'h1094,               0, 0);
    add_row(U_ADD,  F3_NONE,    0, 20, 9, 23, 0,     1, 64'h1096,               0, 0);
    add_row(U_INV,  F3_NONE,    0,  5, 1, 1, 0,      0, 0,                      0, 0);
    add_row(U_SUB,  F3_NONE,    0, 24, 22, 21, 0,    1, 4,                      0, 0);
    add_row(U_OR,   F3_NONE,    0, 25, 5, 0, 0,      1, 64'h1234_5000,          0, 0);
    add_row(U_ADD,  F3_NONE,    1, 26, 0, 0, 1,      1, 1,                      0, 0);
    add_row(U_ADD,  F3_NONE,    1, 26, 0, 0, 2,      1, 2,                      0, 0);
    add_row(U_ADD,  F3_NONE,    0, 27, 26, 26, 0,    1, 4,                      0, 0); // ex0 wins
endtask

// File: dv/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    import exec_pkg::*;

    localparam int       WB_TIMEOUT = 20;
    localparam int       RST_CYCLES = 4;
    localparam t_xdata   PC_BASE    = 64'h1000;
    localparam t_br_cond F3_NONE    = RV_BR_BEQ;   // Ignored by non-branch ops

    typedef struct packed {
        t_iss_pkt pkt;
        logic     exp_wr;
        t_reg_idx exp_rd;
        t_xdata   exp_data;
        logic     exp_mp;
        t_xdata   exp_tgt;
    } t_row;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            iss;
    t_iss_pkt        iss_pkt;
    logic            wb_vld;
    t_wb_pkt         wb_pkt;
    t_br_mispred_pkt br_mispred;

    t_row        rows [$];
    int unsigned issue_cycle [$];
    int unsigned cycle_cnt = 0;

    exec_top exec_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .iss        (iss),
        .iss_pkt    (iss_pkt),
        .wb_vld     (wb_vld),
        .wb_pkt     (wb_pkt),
        .br_mispred (br_mispred)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table construction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic void add_row(t_uop uop, t_br_cond f3, int use_imm, int rd, int rs1,
                                    int rs2, longint imm, int exp_wr, longint exp_data,
                                    int exp_mp, longint exp_tgt);
        t_row row;
        row                    = '0;
        row.pkt.uinstr.uop     = uop;
        row.pkt.uinstr.funct3  = f3;
        row.pkt.uinstr.use_imm = (use_imm != 0);
        row.pkt.uinstr.rd      = t_reg_idx'(rd);
        row.pkt.uinstr.rs1     = t_reg_idx'(rs1);
        row.pkt.uinstr.rs2     = t_reg_idx'(rs2);
        row.pkt.uinstr.imm64   = t_xdata'(imm);
        row.pkt.uinstr.pc      = PC_BASE + t_xdata'(4 * rows.size());
        row.pkt.robid          = t_robid'(rows.size());
        row.exp_wr             = (exp_wr != 0);
        row.exp_rd             = t_reg_idx'(rd);
        row.exp_data           = t_xdata'(exp_data);
        row.exp_mp             = (exp_mp != 0);
        row.exp_tgt            = t_xdata'(exp_tgt);
        rows.push_back(row);
    endfunction

    `include "exec_tb_table.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input t_xdata actual, input t_xdata expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_row(input int idx);
        t_row row;
        row = rows[idx];
        check_value($sformatf("row %0d wb latency", idx),
                    t_xdata'(cycle_cnt - issue_cycle[idx]), 2);
        check_value($sformatf("row %0d wb_pkt.robid", idx), t_xdata'(wb_pkt.robid),
                    t_xdata'(row.pkt.robid));
        check_value($sformatf("row %0d wb_pkt.wr_en", idx), t_xdata'(wb_pkt.wr_en),
                    t_xdata'(row.exp_wr));
        check_value($sformatf("row %0d wb_pkt.rd", idx), t_xdata'(wb_pkt.rd),
                    t_xdata'(row.exp_rd));
        if (row.exp_wr) begin
            check_value($sformatf("row %0d wb_pkt.data", idx), wb_pkt.data, row.exp_data);
        end
        check_value($sformatf("row %0d br_mispred.valid", idx), t_xdata'(br_mispred.valid),
                    t_xdata'(row.exp_mp));
        if (row.exp_mp) begin    // Target and robid only mean something on a pulse
            check_value($sformatf("row %0d br_mispred.target_addr", idx),
                        br_mispred.target_addr, row.exp_tgt);
            check_value($sformatf("row %0d br_mispred.robid", idx),
                        t_xdata'(br_mispred.robid), t_xdata'(row.pkt.robid));
        end
    endtask

    task automatic wait_writeback(input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_vld && waited < WB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_vld) begin
            $display("Row %0d did not reach writeback within %0d cycles", idx, WB_TIMEOUT);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_rows();
        for (int i = 0; i < rows.size(); i++) begin
            wait_writeback(i);
            check_row(i);
        end
    endtask

    // One row per cycle with no gaps between issues
    task automatic issue_rows();
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            iss     = 1'b1;
            iss_pkt = rows[i].pkt;
            issue_cycle.push_back(cycle_cnt);
        end
        @(negedge clk);
        iss     = 1'b0;
        iss_pkt = '0;
    endtask

    initial begin
        rst_n   = 1'b0;
        iss     = 1'b0;
        iss_pkt = '0;
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("wb_vld after reset", t_xdata'(wb_vld), 0);
        check_value("br_mispred.valid after reset", t_xdata'(br_mispred.valid), 0);
        fork
            issue_rows();
            check_rows();
        join
        @(negedge clk);
        check_value("wb_vld after drain", t_xdata'(wb_vld), 0);
        check_value("br_mispred.valid after drain", t_xdata'(br_mispred.valid), 0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: compile.f
+incdir+dv
hw/exec_pkg.sv
hw/exec_operand_read.sv
hw/ibr.sv
hw/ialu.sv
hw/exec_writeback.sv
hw/exec_top.sv
dv/exec_tb.sv

// File: Bender.yml
package:
  name: exec_slice

sources:
  - files:
      - hw/exec_pkg.sv
      - hw/exec_operand_read.sv
      - hw/ibr.sv
      - hw/ialu.sv
      - hw/exec_writeback.sv
      - hw/exec_top.sv

  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/exec_tb.sv
